// File: design/dispatch_ring_pkg.sv
`default_nettype none

package dispatch_ring_pkg;

    localparam int XLEN          = 32;
    localparam int PHYS_REG_SIZE = 256;
    localparam int ROB_SIZE      = 256;
    localparam int PREG_W        = $clog2(PHYS_REG_SIZE);
    localparam int ROB_W         = $clog2(ROB_SIZE);

    // one station per functional unit
    localparam int NUM_UNITS     = 5;

    // unit codes as they arrive from decode
    typedef enum logic [2:0] {
        FU_NONE    = 3'd0,
        FU_LOGICAL = 3'd1,
        FU_ARITH   = 3'd2,
        FU_BRANCH  = 3'd3,
        FU_LD_ST   = 3'd4,
        FU_MUL_DIV = 3'd5
    } fu_e;

    // unit served at each ring position, head first
    localparam fu_e RING_ORDER [NUM_UNITS] = '{
        FU_ARITH,
        FU_LOGICAL,
        FU_BRANCH,
        FU_MUL_DIV,
        FU_LD_ST
    };

    // micro-op payload, carried untouched from intake to issue
    typedef struct packed {
        logic [ROB_W-1:0]  rob_entry;
        logic [PREG_W-1:0] rs1_reg;
        logic              rs1_received;
        logic [XLEN-1:0]   rs1_value;
        logic [XLEN-1:0]   pc;
        logic [4:0]        opcode;           // not decoded here
        logic [2:0]        opcode_type;
        logic              additional_info;
        logic [XLEN-1:0]   rs2_value;
        logic              rs2_received;
        logic [PREG_W-1:0] rs2_reg;
    } uop_t;

    // one slot of the ring
    typedef struct packed {
        logic valid;
        fu_e  unit;
        uop_t uop;
    } ring_slot_t;

    // four-phase req/ack sequencing
    //   HS_IDLE     nothing outstanding
    //   HS_REQ      request pending, ack not yet seen
    //   HS_RELEASE  ack given, waiting for the return to zero
    typedef enum logic [1:0] {
        HS_IDLE    = 2'd0,
        HS_REQ     = 2'd1,
        HS_RELEASE = 2'd2
    } hs_state_e;

endpackage

`default_nettype wire

// File: design/ring_injector.sv
`default_nettype none

module ring_injector (
    input  wire logic                          clk,
    input  wire logic                          rst_n,

    // decode side, four-phase
    input  wire logic                          intake_req,
    input  wire dispatch_ring_pkg::fu_e        intake_unit,
    input  wire dispatch_ring_pkg::uop_t       intake_uop,
    output logic                               intake_ack,
    output logic                               rejected,

    // ring side
    input  wire dispatch_ring_pkg::ring_slot_t wrap_slot,
    output dispatch_ring_pkg::ring_slot_t      head_slot
);

    dispatch_ring_pkg::hs_state_e state;
    logic                         unit_known;
    logic                         accept;

    // any code with a station on the ring is a real unit
    always_comb begin
        unit_known = 1'b0;
        for (int i = 0; i < dispatch_ring_pkg::NUM_UNITS; i++) begin
            if (intake_unit == dispatch_ring_pkg::RING_ORDER[i]) begin
                unit_known = 1'b1;
            end
        end
    end

    // a new micro-op only goes in where a bubble comes round
    assign accept = (state != dispatch_ring_pkg::HS_RELEASE)
                  && intake_req
                  && !wrap_slot.valid;

    always_comb begin
        head_slot = wrap_slot;              // circulating traffic has priority
        if (accept && unit_known) begin
            head_slot.valid = 1'b1;
            head_slot.unit  = intake_unit;
            head_slot.uop   = intake_uop;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= dispatch_ring_pkg::HS_IDLE;
            rejected <= 1'b0;
        end else begin
            rejected <= accept && !unit_known;  // acked but dropped
            case (state)
                dispatch_ring_pkg::HS_IDLE,
                dispatch_ring_pkg::HS_REQ: begin
                    if (accept) begin
                        state <= dispatch_ring_pkg::HS_RELEASE;
                    end else if (intake_req) begin
                        state <= dispatch_ring_pkg::HS_REQ;   // ring full, stall
                    end else begin
                        state <= dispatch_ring_pkg::HS_IDLE;
                    end
                end
                dispatch_ring_pkg::HS_RELEASE: begin
                    // ack drops once the requester lets go
                    if (!intake_req) begin
                        state <= dispatch_ring_pkg::HS_IDLE;
                    end
                end
                default: begin
                    state <= dispatch_ring_pkg::HS_IDLE;
                end
            endcase
        end
    end

    assign intake_ack = (state == dispatch_ring_pkg::HS_RELEASE);

endmodule

`default_nettype wire

// File: design/ring_station.sv
`default_nettype none

module ring_station #(
    parameter dispatch_ring_pkg::fu_e station_unit = dispatch_ring_pkg::FU_ARITH
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,

    // ring links
    input  wire dispatch_ring_pkg::ring_slot_t slot_in,
    output dispatch_ring_pkg::ring_slot_t      slot_out,

    // four-phase issue port to the functional unit
    output logic                               issue_req,
    input  wire logic                          issue_ack,
    output dispatch_ring_pkg::uop_t            issue_uop
);

    // ring slot register
    logic                         slot_valid;
    dispatch_ring_pkg::fu_e       slot_unit;
    dispatch_ring_pkg::uop_t      slot_uop;

    dispatch_ring_pkg::hs_state_e state;
    logic                         unit_match;
    logic                         take;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_valid <= 1'b0;
        end else begin
            slot_valid <= slot_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        slot_unit <= slot_in.unit;
        slot_uop  <= slot_in.uop;
    end

    assign unit_match = slot_valid && (slot_unit == station_unit);

    // leave the ring only if the port has finished its last transfer
    assign take = unit_match && (state == dispatch_ring_pkg::HS_IDLE);

    always_comb begin
        slot_out.valid = slot_valid && !take;   // bubble behind an issued uop
        slot_out.unit  = slot_unit;
        slot_out.uop   = slot_uop;
    end

    // issue register loads only while the port is idle
    always_ff @(posedge clk) begin
        if (take) begin
            issue_uop <= slot_uop;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= dispatch_ring_pkg::HS_IDLE;
        end else begin
            case (state)
                dispatch_ring_pkg::HS_IDLE: begin
                    if (take) begin
                        state <= dispatch_ring_pkg::HS_REQ;
                    end
                end
                dispatch_ring_pkg::HS_REQ: begin
                    // unit has the payload so req drops
                    if (issue_ack) begin
                        state <= dispatch_ring_pkg::HS_RELEASE;
                    end
                end
                dispatch_ring_pkg::HS_RELEASE: begin
                    if (!issue_ack) begin
                        state <= dispatch_ring_pkg::HS_IDLE;
                    end
                end
                default: begin
                    state <= dispatch_ring_pkg::HS_IDLE;
                end
            endcase
        end
    end

    assign issue_req = (state == dispatch_ring_pkg::HS_REQ);

endmodule

`default_nettype wire

// File: design/dispatch_ring.sv
`default_nettype none

module dispatch_ring (
    input  wire logic                                    clk,
    input  wire logic                                    rst_n,

    // intake from decode
    input  wire logic                                    intake_req,
    input  wire dispatch_ring_pkg::fu_e                  intake_unit,
    input  wire dispatch_ring_pkg::uop_t                 intake_uop,
    output wire logic                                    intake_ack,
    output wire logic                                    rejected,

    // issue ports, indexed by ring position
    output wire logic [dispatch_ring_pkg::NUM_UNITS-1:0] issue_req,
    input  wire logic [dispatch_ring_pkg::NUM_UNITS-1:0] issue_ack,
    output wire dispatch_ring_pkg::uop_t                 issue_uop [dispatch_ring_pkg::NUM_UNITS]
);

    // ring_link[0] is the head, ring_link[k+1] leaves station k,
    // the last one wraps back into the injector
    wire dispatch_ring_pkg::ring_slot_t ring_link [dispatch_ring_pkg::NUM_UNITS+1];

    ring_injector u_injector (
        .clk        (clk),
        .rst_n      (rst_n),
        .intake_req (intake_req),
        .intake_unit(intake_unit),
        .intake_uop (intake_uop),
        .intake_ack (intake_ack),
        .rejected   (rejected),
        .wrap_slot  (ring_link[dispatch_ring_pkg::NUM_UNITS]),
        .head_slot  (ring_link[0])
    );

    // arith, logical, branch, mul_div, ld_st
    for (genvar i = 0; i < dispatch_ring_pkg::NUM_UNITS; i++) begin : g_station
        ring_station #(
            .station_unit(dispatch_ring_pkg::RING_ORDER[i])
        ) u_station (
            .clk      (clk),
            .rst_n    (rst_n),
            .slot_in  (ring_link[i]),
            .slot_out (ring_link[i+1]),
            .issue_req(issue_req[i]),
            .issue_ack(issue_ack[i]),
            .issue_uop(issue_uop[i])
        );
    end

endmodule

`default_nettype wire

// File: bench/unit_responder.sv
`default_nettype none

// model of one functional unit on the four-phase issue port
module unit_responder #(
    parameter int MAX_DELAY = 6
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic req,
    input  wire logic hold,     // unit stalled, ack withheld
    output logic      ack
);
    timeunit 1ns;
    timeprecision 100ps;

    logic        busy;          // delay count running
    int unsigned wait_left;
    int unsigned delay;

    initial begin
        ack       = 1'b0;
        busy      = 1'b0;
        wait_left = 0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            ack       <= 1'b0;
            busy      <= 1'b0;
            wait_left <= 0;
        end else if (ack) begin
            if (!req) begin
                ack <= 1'b0;    // return to zero
            end
        end else if (req && !hold) begin
            if (!busy) begin
                // fresh request, pick how long the unit takes to accept it
                delay = $urandom % (MAX_DELAY + 1);
                if (delay == 0) begin
                    ack <= 1'b1;
                end else begin
                    busy      <= 1'b1;
                    wait_left <= delay;
                end
            end else if (wait_left == 1) begin
                busy <= 1'b0;
                ack  <= 1'b1;
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/dispatch_ring_tb.sv
`default_nettype none

module dispatch_ring_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD     = 100;
    localparam int RST_CYCLES = 16;
    localparam int SEED       = 48;
    localparam int MAX_DELAY  = 6;
    localparam int N_RANDOM   = 40;
    localparam int N_UOPS     = 5 + 3 + 8 + 7 + N_RANDOM;
    localparam int NU         = dispatch_ring_pkg::NUM_UNITS;
    localparam int VAL_W      = $bits(dispatch_ring_pkg::uop_t);

    // unit served at each ring position
    localparam dispatch_ring_pkg::fu_e STATION_UNIT [NU] = '{
        dispatch_ring_pkg::FU_ARITH,
        dispatch_ring_pkg::FU_LOGICAL,
        dispatch_ring_pkg::FU_BRANCH,
        dispatch_ring_pkg::FU_MUL_DIV,
        dispatch_ring_pkg::FU_LD_ST
    };

    logic                     clk;
    logic                     rst_n;
    logic                     intake_req;
    dispatch_ring_pkg::fu_e   intake_unit;
    dispatch_ring_pkg::uop_t  intake_uop;
    wire                      intake_ack;
    wire                      rejected;
    wire [NU-1:0]             issue_req;
    wire [NU-1:0]             issue_ack;
    wire dispatch_ring_pkg::uop_t issue_uop [NU];
    logic [NU-1:0]            hold;

    // scoreboard holds one entry per accepted micro-op still owed an issue
    int                       exp_pos [$];
    dispatch_ring_pkg::uop_t  exp_uop [$];
    int                       serial;

    // monitor history
    logic                     intake_ack_q;
    logic                     rejected_q;
    logic [NU-1:0]            issue_req_q;
    logic [NU-1:0]            issue_ack_q;
    dispatch_ring_pkg::uop_t  issue_uop_q [NU];
    logic                     seen_req;
    logic                     latency_on;
    time                      ack_rise_time;

    dispatch_ring UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .intake_req (intake_req),
        .intake_unit(intake_unit),
        .intake_uop (intake_uop),
        .intake_ack (intake_ack),
        .rejected   (rejected),
        .issue_req  (issue_req),
        .issue_ack  (issue_ack),
        .issue_uop  (issue_uop)
    );

    for (genvar k = 0; k < NU; k++) begin : g_unit
        unit_responder #(
            .MAX_DELAY(MAX_DELAY)
        ) u_unit (
            .clk  (clk),
            .rst_n(rst_n),
            .req  (issue_req[k]),
            .hold (hold[k]),
            .ack  (issue_ack[k])
        );
    end

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic report_fail(input string what);
        $display("%s at %0d ns", what, $time);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic value_fail(input string name, input logic [VAL_W-1:0] expected,
                              input logic [VAL_W-1:0] actual);
        $display("FAILED at %0d ns: %s expected %0h got %0h", $time, name, expected, actual);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    function automatic int unit_position(input dispatch_ring_pkg::fu_e unit);
        int pos;
        pos = -1;   // no station for this code
        for (int p = 0; p < NU; p++) begin
            if (STATION_UNIT[p] == unit) begin
                pos = p;
            end
        end
        return pos;
    endfunction

    function automatic int pending_at(input int pos);
        int n;
        n = 0;
        foreach (exp_pos[i]) begin
            if (exp_pos[i] == pos) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic dispatch_ring_pkg::uop_t make_uop(input int tag);
        dispatch_ring_pkg::uop_t u;
        u.rob_entry       = dispatch_ring_pkg::ROB_W'(tag);    // unique per run
        u.rs1_reg         = dispatch_ring_pkg::PREG_W'($urandom);
        u.rs1_received    = 1'($urandom);
        u.rs1_value       = $urandom;
        u.pc              = $urandom;
        u.opcode          = 5'($urandom);
        u.opcode_type     = 3'($urandom);
        u.additional_info = 1'($urandom);
        u.rs2_value       = $urandom;
        u.rs2_received    = 1'($urandom);
        u.rs2_reg         = dispatch_ring_pkg::PREG_W'($urandom);
        return u;
    endfunction

    // remove one matching entry for this port
    task automatic retire(input int pos, input dispatch_ring_pkg::uop_t uop);
        int hit;
        hit = -1;
        for (int i = 0; i < exp_pos.size(); i++) begin
            if (hit < 0 && exp_pos[i] == pos && exp_uop[i] == uop) begin
                hit = i;
            end
        end
        assert (hit >= 0) else report_fail($sformatf(
            "issue port %0d delivered a micro-op that was never sent to its unit", pos));
        exp_pos.delete(hit);
        exp_uop.delete(hit);
    endtask

    task automatic raise_request(input dispatch_ring_pkg::fu_e unit,
                                 input dispatch_ring_pkg::uop_t uop);
        @(posedge clk);
        while (intake_ack) begin
            @(posedge clk);     // previous transfer still returning to zero
        end
        intake_req  <= 1'b1;
        intake_unit <= unit;
        intake_uop  <= uop;
    endtask

    task automatic complete_request(input dispatch_ring_pkg::fu_e unit,
                                    input dispatch_ring_pkg::uop_t uop);
        int pos;
        pos = unit_position(unit);
        do begin
            @(posedge clk);
        end while (!intake_ack);
        assert (rejected == (pos < 0)) else value_fail("rejected", pos < 0, rejected);
        if (pos >= 0) begin
            exp_pos.push_back(pos);
            exp_uop.push_back(uop);
        end
        intake_req <= 1'b0;
    endtask

    task automatic send_uop(input dispatch_ring_pkg::fu_e unit);
        dispatch_ring_pkg::uop_t uop;
        uop = make_uop(serial);
        serial++;
        raise_request(unit, uop);
        complete_request(unit, uop);
    endtask

    task automatic wait_drained();
        do begin
            @(posedge clk);
        end while (exp_pos.size() != 0 || issue_req != '0 || issue_ack != '0);
        repeat (2) @(posedge clk);  // ports back to idle
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (!seen_req) begin
                assert (!intake_ack) else value_fail("intake_ack", 0, intake_ack);
                assert (!rejected) else value_fail("rejected", 0, rejected);
                assert (issue_req == '0) else value_fail("issue_req", 0, issue_req);
            end
            if (intake_ack && !intake_ack_q) begin
                assert (intake_req) else report_fail("intake_ack rose without intake_req");
                ack_rise_time = $time;
            end
            if (rejected) begin
                assert (!rejected_q) else report_fail("rejected stayed high past one cycle");
                assert (intake_ack && !intake_ack_q)
                    else report_fail("rejected rose without a fresh intake_ack");
            end
            for (int k = 0; k < NU; k++) begin
                if (issue_ack[k] && !issue_ack_q[k]) begin
                    assert (issue_req[k]) else report_fail($sformatf(
                        "issue_ack[%0d] rose without issue_req", k));
                end
                if (issue_req[k] && issue_req_q[k]) begin
                    assert (issue_uop[k] == issue_uop_q[k]) else value_fail(
                        $sformatf("issue_uop[%0d]", k), issue_uop_q[k], issue_uop[k]);
                end
                if (issue_req[k] && !issue_req_q[k]) begin
                    assert (!issue_ack[k]) else report_fail($sformatf(
                        "issue_req[%0d] rose again before issue_ack fell", k));
                    if (latency_on) begin
                        assert ($time - ack_rise_time == (k + 1) * PERIOD) else value_fail(
                            $sformatf("issue_req[%0d] delay ns", k),
                            (k + 1) * PERIOD, $time - ack_rise_time);
                    end
                    retire(k, issue_uop[k]);
                end
            end
            if (intake_req) begin
                seen_req = 1'b1;
            end
        end
        intake_ack_q = intake_ack;
        rejected_q   = rejected;
        issue_req_q  = issue_req;
        issue_ack_q  = issue_ack;
        issue_uop_q  = issue_uop;
    end

    initial begin
        repeat (RST_CYCLES + N_UOPS * 200) @(posedge clk);
        report_fail("watchdog expired before the tests finished");
    end

    initial begin
        int                      guard;
        dispatch_ring_pkg::uop_t uop;
        void'($urandom(SEED));
        rst_n       = 1'b0;
        intake_req  = 1'b0;
        intake_unit = dispatch_ring_pkg::FU_NONE;
        intake_uop  = '0;
        hold        = '0;
        serial      = 0;
        seen_req    = 1'b0;
        latency_on  = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);

        // one micro-op in flight per unit
        latency_on <= 1'b1;
        for (int p = 0; p < NU; p++) begin
            send_uop(STATION_UNIT[p]);
            wait_drained();
        end
        latency_on <= 1'b0;

        send_uop(dispatch_ring_pkg::fu_e'(3'd0));
        send_uop(dispatch_ring_pkg::fu_e'(3'd6));
        send_uop(dispatch_ring_pkg::fu_e'(3'd7));
        wait_drained();

        // branch port stalled while other traffic keeps flowing
        hold <= 5'b00100;
        send_uop(dispatch_ring_pkg::FU_BRANCH);
        send_uop(dispatch_ring_pkg::FU_BRANCH);
        send_uop(dispatch_ring_pkg::FU_ARITH);
        send_uop(dispatch_ring_pkg::FU_LOGICAL);
        send_uop(dispatch_ring_pkg::FU_MUL_DIV);
        send_uop(dispatch_ring_pkg::FU_LD_ST);
        send_uop(dispatch_ring_pkg::FU_LOGICAL);
        send_uop(dispatch_ring_pkg::FU_ARITH);
        guard = 0;
        while (exp_pos.size() != pending_at(2) && guard < 200) begin
            @(posedge clk);
            guard++;
        end
        assert (exp_pos.size() == pending_at(2))
            else report_fail("traffic for other units stalled behind the held branch port");
        assert (pending_at(2) == 1) else value_fail("branch uops circulating", 1, pending_at(2));
        hold <= '0;
        wait_drained();

        // one arith in the issue register and five more filling the ring
        hold <= '1;
        repeat (6) send_uop(dispatch_ring_pkg::FU_ARITH);
        uop = make_uop(serial);
        serial++;
        raise_request(dispatch_ring_pkg::FU_ARITH, uop);
        repeat (30) begin
            @(posedge clk);
            assert (!intake_ack) else report_fail("intake_ack rose while every ring slot was full");
        end
        hold <= '0;
        complete_request(dispatch_ring_pkg::FU_ARITH, uop);
        wait_drained();

        repeat (N_RANDOM) send_uop(dispatch_ring_pkg::fu_e'(3'($urandom % 8)));
        wait_drained();

        if (exp_pos.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            report_fail("accepted micro-ops were never issued");
        end
    end

endmodule

`default_nettype wire

// File: compile.f
design/dispatch_ring_pkg.sv
design/ring_injector.sv
design/ring_station.sv
design/dispatch_ring.sv
bench/unit_responder.sv
bench/dispatch_ring_tb.sv
